// ==== filelist.f ====
+incdir+verilog
verilog/tlk_ctrl_pkg.sv
verilog/tlk_frame_pkg.sv
verilog/tlk_tx_framer.sv
verilog/tlk_rx_checker.sv
verilog/tlk_link_ctrl.sv
verilog/tlk2711_link.sv
verification/tb_clkgen.sv
verification/tlk2711_link_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the link testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f \
    --top-module tlk2711_link_tb -o tlk2711_link_sim
./obj_dir/tlk2711_link_sim

// ==== verification/tb_clkgen.sv ====
`timescale 1ns/1ns

// free running clock, 8 ns period.
module tb_clkgen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #4 clk_o = ~clk_o;

endmodule

// ==== verification/tlk2711_link_tb.sv ====
`timescale 1ns/1ns
`include "tlk_macros.svh"

module tlk2711_link_tb;

    localparam int TIMEOUT_CYCLES = 6 * 12 * `TLK_FRAME_WORDS * 2 + 500;

    logic        clk_80;
    logic        rst_i;
    logic        start_i;
    logic [1:0]  mode_i;
    logic        stop_req_i;
    logic        stop_ack_o;
    logic [15:0] txd_o;
    logic        tkmsb_o;
    logic        tklsb_o;
    logic        enable_o;
    logic        lckrefn_o;
    logic        loopen_o;
    logic        prbsen_o;
    logic        link_up_o;
    logic [15:0] frames_o;
    logic [15:0] errors_o;

    // loopback register with an optional bit flip.
    logic [15:0] rxd_q = 16'h0000;
    logic        rkmsb_q = 1'b0;
    logic        rklsb_q = 1'b0;
    logic [15:0] flip_mask = 16'h0000;

    logic [15:0] rng_state = 16'd64;
    int          cycles = 0;
    int          fail_count = 0;
    string       cur_test = "reset";

    // frame model state.
    tlk_ctrl_pkg::tlk_mode_e m_mode = tlk_ctrl_pkg::MODE_IDLE;
    int          m_pend = 0;
    bit          m_on = 1'b0;
    int          m_idx = 0;
    logic [15:0] m_seq = 16'h0000;
    bit          m_stop = 1'b0;
    bit          m_check_ack = 1'b0;
    int          corr_word[16];
    int          corr_bit[16];
    int          lu_down = 0;
    int          lu_up = 0;
    logic [15:0] exp_frames = 16'h0000;
    logic [15:0] exp_errors = 16'h0000;

    tb_clkgen u_clkgen (
        .clk_o (clk_80)
    );

    tlk2711_link u_tlk2711_link (
        .clk_80     (clk_80),
        .rst_i      (rst_i),
        .start_i    (start_i),
        .mode_i     (mode_i),
        .stop_req_i (stop_req_i),
        .stop_ack_o (stop_ack_o),
        .txd_o      (txd_o),
        .tkmsb_o    (tkmsb_o),
        .tklsb_o    (tklsb_o),
        .enable_o   (enable_o),
        .lckrefn_o  (lckrefn_o),
        .loopen_o   (loopen_o),
        .prbsen_o   (prbsen_o),
        .rxd_i      (rxd_q),
        .rkmsb_i    (rkmsb_q),
        .rklsb_i    (rklsb_q),
        .link_up_o  (link_up_o),
        .frames_o   (frames_o),
        .errors_o   (errors_o)
    );

    always @(posedge clk_80) begin
        rxd_q   <= txd_o ^ flip_mask;
        rkmsb_q <= tkmsb_o;
        rklsb_q <= tklsb_o;
    end

    function automatic logic [15:0] rng_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hD008) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output int unsigned v);
        v = 0;
        repeat (n) begin
            rng_state = rng_step(rng_state);
            v = {v[30:0], rng_state[0]};
        end
    endtask

    // expected {kmsb, klsb, data} of word idx in frame seq.
    function automatic logic [17:0] model_word(input tlk_ctrl_pkg::tlk_mode_e mode,
                                               input logic [15:0] seq, input int idx);
        logic [15:0] s;
        if (idx == 0) begin
            return {2'b11, `TLK_COMMA};
        end
        if (idx == 1) begin
            return {2'b00, seq};
        end
        if (mode == tlk_ctrl_pkg::MODE_PRBS) begin
            s = {seq[14:0], 1'b1};
            repeat (idx - 1) begin
                s = s[0] ? ((s >> 1) ^ `TLK_PRBS_TAPS) : (s >> 1);
            end
            return {2'b00, s};
        end
        return {2'b00, seq[7:0], 8'(idx)};
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_count++;
            $display("Mismatch in %s (%s): expected %0h, actual %0h", cur_test, what, exp, act);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic pins_check(input bit active);
        check_val("pins",
                  32'({active, active, active && (m_mode == tlk_ctrl_pkg::MODE_LOOP),
                       active && (m_mode == tlk_ctrl_pkg::MODE_PRBS)}),
                  32'({enable_o, lckrefn_o, loopen_o, prbsen_o}));
    endtask

    // one clock, then advance the model and check the transmit side.
    task automatic step();
        bit          prev_final;
        logic [17:0] exp_w;
        @(negedge clk_80);
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: no progress after %0d cycles in %s", cycles, cur_test);
            $display("Some tests failed");
            $fatal(1);
        end
        prev_final = m_on && (m_idx == 7) && m_stop;
        if (m_pend > 0) begin
            m_pend--;
            if (m_pend == 0) begin
                m_on  = 1'b1;
                m_idx = 0;
                m_seq = 16'h0000;
            end
        end else if (m_on) begin
            m_idx++;
            if (m_idx == `TLK_FRAME_WORDS) begin
                m_idx = 0;
                m_seq = m_seq + 16'd1;
                if (m_stop) begin
                    m_on = 1'b0;
                end
            end
        end
        exp_w = m_on ? model_word(m_mode, m_seq, m_idx) : {2'b11, `TLK_COMMA};
        check_val("tx word", 32'(exp_w), 32'({tkmsb_o, tklsb_o, txd_o}));
        if (m_check_ack) begin
            check_val("stop_ack", 32'(prev_final), 32'(stop_ack_o));
        end
        if (lu_down > 0) begin
            lu_down--;
            if (lu_down == 0) begin
                check_val("link_up after bad comma", 32'(0), 32'(link_up_o));
            end
        end
        if (lu_up > 0) begin
            lu_up--;
            if (lu_up == 0) begin
                check_val("link_up after next comma", 32'(1), 32'(link_up_o));
            end
        end
        flip_mask = 16'h0000;
        if (m_on && (corr_word[m_seq[3:0]] == m_idx)) begin
            flip_mask = 16'(1) << corr_bit[m_seq[3:0]];
            if (m_idx == 0) begin
                lu_down = 3;
                lu_up   = 11;
            end
        end
    endtask

    // one start/stop cycle of n frames in the given mode.
    task automatic run_link(input string name, input tlk_ctrl_pkg::tlk_mode_e mode,
                            input int n, input bit corrupt, input bit lose_comma);
        int unsigned r;
        int          w;
        bit          prev_lost;
        cur_test  = name;
        m_mode    = mode;
        prev_lost = 1'b0;
        for (int k = 0; k < 16; k++) begin
            corr_word[k] = -1;
            corr_bit[k]  = 0;
        end
        if (mode != tlk_ctrl_pkg::MODE_IDLE) begin
            exp_frames = exp_frames + 16'(n);
        end
        // at most one bad word per frame.
        // the frame after a lost comma takes its sequence number as received.
        if (corrupt) begin
            for (int k = 1; k < n; k++) begin
                rand_bits(1, r);
                if (r == 1 || k == 1) begin
                    rand_bits(3, r);
                    w = int'(r);
                    if (lose_comma && k == 1) begin
                        w = 0;
                    end
                    // a comma lost in the last frame would relock only after stop.
                    if (w == 0 && k == n - 1) begin
                        w = 2;
                    end
                    if (w == 1 && prev_lost) begin
                        w = 2;
                    end
                    rand_bits(4, r);
                    corr_word[k] = w;
                    corr_bit[k]  = int'(r);
                    if (w == 0) begin
                        exp_frames = exp_frames - 16'd1;
                    end else begin
                        exp_errors = exp_errors + 16'd1;
                    end
                    prev_lost = (w == 0);
                end else begin
                    prev_lost = 1'b0;
                end
            end
        end

        mode_i      = mode;
        start_i     = 1'b1;
        m_check_ack = (mode != tlk_ctrl_pkg::MODE_IDLE);
        if (mode != tlk_ctrl_pkg::MODE_IDLE) begin
            m_pend = 2;
        end
        step();
        start_i = 1'b0;
        // the captured mode must not follow the input.
        mode_i  = ~mode;
        pins_check(1'b1);

        if (mode == tlk_ctrl_pkg::MODE_IDLE) begin
            repeat (12) begin
                step();
                pins_check(1'b1);
                check_val("idle link_up", 32'(1), 32'(link_up_o));
                check_val("idle frames", 32'(exp_frames), 32'(frames_o));
            end
        end else begin
            while (!(m_on && (m_seq == 16'(n - 1)) && (m_idx == 2))) begin
                step();
                pins_check(1'b1);
            end
        end

        stop_req_i = 1'b1;
        m_stop     = 1'b1;
        while (!stop_ack_o) begin
            step();
            pins_check(1'b1);
        end
        stop_req_i = 1'b0;
        step();
        check_val("stop_ack fall", 32'(0), 32'(stop_ack_o));
        pins_check(1'b0);
        m_check_ack = 1'b0;
        m_stop      = 1'b0;

        repeat (4) begin
            step();
        end
        check_val("frames", 32'(exp_frames), 32'(frames_o));
        check_val("errors", 32'(exp_errors), 32'(errors_o));
    endtask

    initial begin
        int unsigned len;
        int unsigned pick;
        rst_i      = 1'b1;
        start_i    = 1'b0;
        stop_req_i = 1'b0;
        mode_i     = 2'd0;
        repeat (8) begin
            @(negedge clk_80);
        end
        rst_i = 1'b0;

        step();
        pins_check(1'b0);
        check_val("stop_ack", 32'(0), 32'(stop_ack_o));
        check_val("link_up", 32'(0), 32'(link_up_o));
        check_val("frames", 32'(0), 32'(frames_o));
        check_val("errors", 32'(0), 32'(errors_o));

        rand_bits(3, len);
        run_link("count", tlk_ctrl_pkg::MODE_COUNT, int'(len) + 3, 1'b0, 1'b0);
        rand_bits(3, len);
        run_link("prbs", tlk_ctrl_pkg::MODE_PRBS, int'(len) + 3, 1'b0, 1'b0);
        rand_bits(3, len);
        rand_bits(1, pick);
        run_link("corrupt", pick == 1 ? tlk_ctrl_pkg::MODE_PRBS : tlk_ctrl_pkg::MODE_COUNT,
                 int'(len) + 3, 1'b1, 1'b0);
        run_link("idle", tlk_ctrl_pkg::MODE_IDLE, 0, 1'b0, 1'b0);
        rand_bits(3, len);
        run_link("loopback", tlk_ctrl_pkg::MODE_LOOP, int'(len) + 3, 1'b0, 1'b0);
        rand_bits(3, len);
        run_link("loopback corrupt", tlk_ctrl_pkg::MODE_LOOP, int'(len) + 3, 1'b1, 1'b1);

        if (fail_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1);
        end
    end

endmodule

// ==== verilog/tlk2711_link.sv ====
`timescale 1ns/1ns
`include "tlk_macros.svh"

module tlk2711_link (
    input  logic                  clk_80,
    input  logic                  rst_i,
    input  logic                  start_i,
    input  logic [1:0]            mode_i,
    input  logic                  stop_req_i,
    output logic                  stop_ack_o,
    output logic [15:0]           txd_o,
    output logic                  tkmsb_o,
    output logic                  tklsb_o,
    output logic                  enable_o,
    output logic                  lckrefn_o,
    output logic                  loopen_o,
    output logic                  prbsen_o,
    input  logic [15:0]           rxd_i,
    input  logic                  rkmsb_i,
    input  logic                  rklsb_i,
    output logic                  link_up_o,
    output logic [`TLK_CNT_W-1:0] frames_o,
    output logic [`TLK_CNT_W-1:0] errors_o
);

    logic                        run;
    logic                        frame_end;
    tlk_ctrl_pkg::tlk_mode_e     run_mode;
    tlk_ctrl_pkg::tlk_pins_t     pins;
    tlk_frame_pkg::tlk_word_t    tx_word;
    tlk_frame_pkg::tlk_word_t    rx_word;
    tlk_frame_pkg::link_status_t status;

    assign rx_word = '{kmsb: rkmsb_i, klsb: rklsb_i, data: rxd_i};

    tlk_link_ctrl u_link_ctrl (
        .clk_80      (clk_80),
        .rst_i       (rst_i),
        .start_i     (start_i),
        .mode_i      (tlk_ctrl_pkg::tlk_mode_e'(mode_i)),
        .stop_req_i  (stop_req_i),
        .frame_end_i (frame_end),
        .lock_i      (status.lock),
        .run_o       (run),
        .mode_o      (run_mode),
        .pins_o      (pins),
        .stop_ack_o  (stop_ack_o),
        .link_up_o   (link_up_o)
    );

    tlk_tx_framer u_tx_framer (
        .clk_80      (clk_80),
        .rst_i       (rst_i),
        .run_i       (run),
        .mode_i      (run_mode),
        .word_o      (tx_word),
        .frame_end_o (frame_end)
    );

    tlk_rx_checker u_rx_checker (
        .clk_80   (clk_80),
        .rst_i    (rst_i),
        .mode_i   (run_mode),
        .word_i   (rx_word),
        .status_o (status)
    );

    assign txd_o     = tx_word.data;
    assign tkmsb_o   = tx_word.kmsb;
    assign tklsb_o   = tx_word.klsb;
    assign enable_o  = pins.enable;
    assign lckrefn_o = pins.lckrefn;
    assign loopen_o  = pins.loopen;
    assign prbsen_o  = pins.prbsen;
    assign frames_o  = status.frames;
    assign errors_o  = status.errors;

endmodule

// ==== verilog/tlk_ctrl_pkg.sv ====
package tlk_ctrl_pkg;

    typedef enum logic [1:0] {
        MODE_IDLE  = 2'd0,
        MODE_COUNT = 2'd1,
        MODE_PRBS  = 2'd2,
        MODE_LOOP  = 2'd3
    } tlk_mode_e;

    typedef enum logic [1:0] {
        CTRL_OFF   = 2'd0,
        CTRL_RUN   = 2'd1,
        CTRL_DRAIN = 2'd2,
        CTRL_ACK   = 2'd3
    } ctrl_state_e;

    // SERDES mode pins.
    typedef struct packed {
        logic enable;
        logic lckrefn;
        logic loopen;
        logic prbsen;
    } tlk_pins_t;

endpackage

// ==== verilog/tlk_frame_pkg.sv ====
`include "tlk_macros.svh"

package tlk_frame_pkg;

    typedef struct packed {
        logic        kmsb;
        logic        klsb;
        logic [15:0] data;
    } tlk_word_t;

    typedef enum logic {
        CHK_HUNT  = 1'b0,
        CHK_FRAME = 1'b1
    } chk_state_e;

    typedef struct packed {
        logic                  lock;
        logic [`TLK_CNT_W-1:0] frames;
        logic [`TLK_CNT_W-1:0] errors;
    } link_status_t;

    localparam tlk_word_t COMMA_WORD = '{kmsb: 1'b1, klsb: 1'b1, data: `TLK_COMMA};

    function automatic logic [15:0] prbs_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ `TLK_PRBS_TAPS) : (s >> 1);
    endfunction

    // count and loopback payload.
    function automatic logic [15:0] count_word(input logic [15:0] seq, input logic [7:0] idx);
        return {seq[7:0], idx};
    endfunction

endpackage

// ==== verilog/tlk_link_ctrl.sv ====
`timescale 1ns/1ns

module tlk_link_ctrl (
    input  logic                    clk_80,
    input  logic                    rst_i,
    input  logic                    start_i,
    input  tlk_ctrl_pkg::tlk_mode_e mode_i,
    input  logic                    stop_req_i,
    input  logic                    frame_end_i,
    input  logic                    lock_i,
    output logic                    run_o,
    output tlk_ctrl_pkg::tlk_mode_e mode_o,
    output tlk_ctrl_pkg::tlk_pins_t pins_o,
    output logic                    stop_ack_o,
    output logic                    link_up_o
);

    tlk_ctrl_pkg::ctrl_state_e state_q;
    tlk_ctrl_pkg::tlk_mode_e   mode_q;
    logic                      active;

    always_ff @(posedge clk_80) begin
        if (rst_i) begin
            state_q <= tlk_ctrl_pkg::CTRL_OFF;
            mode_q  <= tlk_ctrl_pkg::MODE_IDLE;
        end else begin
            case (state_q)
                tlk_ctrl_pkg::CTRL_OFF: begin
                    if (start_i) begin
                        state_q <= tlk_ctrl_pkg::CTRL_RUN;
                        mode_q  <= mode_i;
                    end
                end
                tlk_ctrl_pkg::CTRL_RUN: begin
                    if (stop_req_i) begin
                        state_q <= tlk_ctrl_pkg::CTRL_DRAIN;
                    end
                end
                tlk_ctrl_pkg::CTRL_DRAIN: begin
                    // idle mode never opens a frame, so there is nothing to drain.
                    if (frame_end_i || (mode_q == tlk_ctrl_pkg::MODE_IDLE)) begin
                        state_q <= tlk_ctrl_pkg::CTRL_ACK;
                    end
                end
                tlk_ctrl_pkg::CTRL_ACK: begin
                    if (!stop_req_i) begin
                        state_q <= tlk_ctrl_pkg::CTRL_OFF;
                    end
                end
                default: begin
                    state_q <= tlk_ctrl_pkg::CTRL_OFF;
                end
            endcase
        end
    end

    assign active = (state_q != tlk_ctrl_pkg::CTRL_OFF);

    always_comb begin
        pins_o.enable  = active;
        pins_o.lckrefn = active;
        pins_o.loopen  = active && (mode_q == tlk_ctrl_pkg::MODE_LOOP);
        pins_o.prbsen  = active && (mode_q == tlk_ctrl_pkg::MODE_PRBS);
    end

    assign run_o      = (state_q == tlk_ctrl_pkg::CTRL_RUN);
    assign mode_o     = mode_q;
    assign stop_ack_o = (state_q == tlk_ctrl_pkg::CTRL_ACK);
    assign link_up_o  = active && lock_i;

    a_ack_needs_req: assert property (
        @(posedge clk_80) disable iff (rst_i)
        stop_ack_o |-> ($past(stop_req_i) || $past(stop_ack_o))
    );

endmodule

// ==== verilog/tlk_macros.svh ====
`ifndef TLK_MACROS_SVH
`define TLK_MACROS_SVH

// K28.5 in both byte lanes, sent with both k flags set.
`define TLK_COMMA 16'hBCBC

// comma, sequence number and six payload words.
`define TLK_FRAME_WORDS 8

// galois tap mask of the 16-bit payload lfsr.
`define TLK_PRBS_TAPS 16'hB400

// the forced low bit keeps the lfsr seed nonzero.
`define TLK_PRBS_SEED(s) {s[14:0], 1'b1}

// width of the frame and error counters.
`define TLK_CNT_W 16

`endif

// ==== verilog/tlk_rx_checker.sv ====
`timescale 1ns/1ns
`include "tlk_macros.svh"

module tlk_rx_checker (
    input  logic                        clk_80,
    input  logic                        rst_i,
    input  tlk_ctrl_pkg::tlk_mode_e     mode_i,
    input  tlk_frame_pkg::tlk_word_t    word_i,
    output tlk_frame_pkg::link_status_t status_o
);

    localparam int IDX_W = $clog2(`TLK_FRAME_WORDS);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`TLK_FRAME_WORDS - 1);
    localparam logic [IDX_W-1:0] SEQ_IDX = IDX_W'(1);

    tlk_frame_pkg::tlk_word_t    word_q;
    tlk_frame_pkg::chk_state_e   state_q;
    tlk_frame_pkg::link_status_t status_q;
    logic [IDX_W-1:0]            idx_q;
    logic [15:0]                 seq_q;
    logic                        first_q;
    logic [15:0]                 lfsr_q;
    logic [15:0]                 lfsr_nxt;
    logic [15:0]                 seq_ref;
    logic [15:0]                 expect_data;
    logic                        is_comma;
    logic                        word_bad;

    assign is_comma = (word_q == tlk_frame_pkg::COMMA_WORD);
    assign lfsr_nxt = tlk_frame_pkg::prbs_step(lfsr_q);

    // after the first frame the expected number replaces a corrupted one.
    assign seq_ref = first_q ? word_q.data : seq_q + 16'd1;

    always_comb begin
        if (idx_q == SEQ_IDX) begin
            expect_data = seq_ref;
        end else if (mode_i == tlk_ctrl_pkg::MODE_PRBS) begin
            expect_data = lfsr_nxt;
        end else begin
            expect_data = tlk_frame_pkg::count_word(seq_q, 8'(idx_q));
        end
    end

    assign word_bad = word_q.kmsb || word_q.klsb || (word_q.data != expect_data);

    always_ff @(posedge clk_80) begin
        word_q <= word_i;
    end

    always_ff @(posedge clk_80) begin
        if (rst_i) begin
            state_q  <= tlk_frame_pkg::CHK_HUNT;
            idx_q    <= '0;
            seq_q    <= '0;
            first_q  <= 1'b1;
            status_q <= '0;
        end else if (is_comma) begin
            // only a comma right after a full frame continues the sequence.
            first_q       <= !((state_q == tlk_frame_pkg::CHK_FRAME) && (idx_q == '0));
            state_q       <= tlk_frame_pkg::CHK_FRAME;
            idx_q         <= SEQ_IDX;
            status_q.lock <= 1'b1;
        end else if (state_q == tlk_frame_pkg::CHK_FRAME) begin
            if (idx_q == '0) begin
                state_q       <= tlk_frame_pkg::CHK_HUNT;
                status_q.lock <= 1'b0;
            end else begin
                if (word_bad && (status_q.errors != '1)) begin
                    status_q.errors <= status_q.errors + 1'b1;
                end
                if (idx_q == SEQ_IDX) begin
                    seq_q <= seq_ref;
                end
                if (idx_q == LAST_IDX) begin
                    status_q.frames <= status_q.frames + 1'b1;
                    idx_q           <= '0;
                end else begin
                    idx_q <= idx_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_80) begin
        if (idx_q == SEQ_IDX) begin
            lfsr_q <= `TLK_PRBS_SEED(seq_ref);
        end else begin
            lfsr_q <= lfsr_nxt;
        end
    end

    assign status_o = status_q;

    a_errors_monotonic: assert property (
        @(posedge clk_80) disable iff (rst_i)
        !$past(rst_i) |-> (status_q.errors >= $past(status_q.errors))
    );

endmodule

// ==== verilog/tlk_tx_framer.sv ====
`timescale 1ns/1ns
`include "tlk_macros.svh"

module tlk_tx_framer (
    input  logic                     clk_80,
    input  logic                     rst_i,
    input  logic                     run_i,
    input  tlk_ctrl_pkg::tlk_mode_e  mode_i,
    output tlk_frame_pkg::tlk_word_t word_o,
    output logic                     frame_end_o
);

    localparam int IDX_W = $clog2(`TLK_FRAME_WORDS);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`TLK_FRAME_WORDS - 1);
    localparam logic [IDX_W-1:0] SEQ_IDX = IDX_W'(1);

    logic [IDX_W-1:0]         idx_q;
    logic [15:0]              seq_q;
    logic [15:0]              lfsr_q;
    logic [15:0]              lfsr_nxt;
    logic                     run_q;
    logic                     in_frame;
    logic                     send;
    logic                     last_word;
    tlk_frame_pkg::tlk_word_t word_d;

    // a started frame runs to its end even after run_i drops.
    assign in_frame  = (idx_q != '0);
    assign send      = in_frame || (run_i && (mode_i != tlk_ctrl_pkg::MODE_IDLE));
    assign last_word = send && (idx_q == LAST_IDX);
    assign lfsr_nxt  = tlk_frame_pkg::prbs_step(lfsr_q);

    always_comb begin
        word_d = tlk_frame_pkg::COMMA_WORD;
        if (send && in_frame) begin
            word_d.kmsb = 1'b0;
            word_d.klsb = 1'b0;
            if (idx_q == SEQ_IDX) begin
                word_d.data = seq_q;
            end else if (mode_i == tlk_ctrl_pkg::MODE_PRBS) begin
                word_d.data = lfsr_nxt;
            end else begin
                word_d.data = tlk_frame_pkg::count_word(seq_q, 8'(idx_q));
            end
        end
    end

    always_ff @(posedge clk_80) begin
        if (rst_i) begin
            idx_q       <= '0;
            seq_q       <= '0;
            run_q       <= 1'b0;
            word_o      <= tlk_frame_pkg::COMMA_WORD;
            frame_end_o <= 1'b0;
        end else begin
            run_q       <= run_i;
            word_o      <= word_d;
            frame_end_o <= last_word;

            if (send) begin
                idx_q <= last_word ? '0 : idx_q + 1'b1;
            end

            // each start numbers its frames from zero.
            if (run_i && !run_q) begin
                seq_q <= '0;
            end else if (last_word) begin
                seq_q <= seq_q + 16'd1;
            end
        end
    end

    // reseeded on the sequence word, stepped before every payload word.
    always_ff @(posedge clk_80) begin
        if (idx_q == SEQ_IDX) begin
            lfsr_q <= `TLK_PRBS_SEED(seq_q);
        end else begin
            lfsr_q <= lfsr_nxt;
        end
    end

    // k flags mark the comma, which only leaves at frame position 0.
    a_k_only_on_comma: assert property (
        @(posedge clk_80) disable iff (rst_i)
        (word_o.kmsb || word_o.klsb) |->
            ((word_o == tlk_frame_pkg::COMMA_WORD) && (idx_q <= SEQ_IDX))
    );

endmodule
